/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_top
FLIST = files.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bench/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker #(
   parameter int n_rows    = 1,
   parameter int mem_words = 64
) (
   input  logic                clk,
   input  logic                rstn,
   input  pipe_pkg::dmem_req_t dmem,
   input  logic [31:0]         retired,
   input  logic [127:0]        names    [n_rows],
   input  logic [31:0]         exp_addr [n_rows],
   input  logic [31:0]         exp_val  [n_rows],
   input  logic                plus_mem [n_rows],
   input  logic [31:0]         src_addr [n_rows],
   input  logic [31:0]         exp_retired,
   input  logic [31:0]         data_mem [mem_words],
   output int                  store_errors,
   output int                  retire_errors,
   output int                  seen,
   output bit                  finished
);

   int settle;
   int loads;

   // load rows store the preloaded word plus the addi immediate
   function automatic logic [31:0] expected_value(input int row);
      if (plus_mem[row]) begin
         return data_mem[src_addr[row][7:2]] + exp_val[row];
      end
      return exp_val[row];
   endfunction

   // each load row reads data memory once
   function automatic int count_load_rows();
      int n;
      n = 0;
      for (int r = 0; r < n_rows; r++) begin
         if (plus_mem[r]) begin
            n++;
         end
      end
      return n;
   endfunction

   always @(negedge clk) begin : watch
      int errs;
      errs = 0;
      if (rstn) begin
         store_errors  <= 0;
         retire_errors <= 0;
         seen          <= 0;
         settle        <= 0;
         loads         <= 0;
         finished      <= 1'b0;
      end else begin
         if (dmem.re) begin
            if (seen >= n_rows || !plus_mem[seen]) begin
               errs++;
               $display("Unexpected load from address %h outside a load row", dmem.addr);
            end else if (dmem.addr !== src_addr[seen]) begin
               errs++;
               $display("Mismatch %s load address: expected %h, actual %h",
                        names[seen], src_addr[seen], dmem.addr);
            end
            loads <= loads + 1;
         end
         if (dmem.we) begin
            if (seen >= n_rows) begin
               errs++;
               $display("Unexpected store of %h to address %h after the last table row",
                        dmem.wdata, dmem.addr);
            end else begin
               if (dmem.addr !== exp_addr[seen]) begin
                  errs++;
                  $display("Mismatch %s address: expected %h, actual %h",
                           names[seen], exp_addr[seen], dmem.addr);
               end
               if (dmem.wdata !== expected_value(seen)) begin
                  errs++;
                  $display("Mismatch %s: expected %h, actual %h",
                           names[seen], expected_value(seen), dmem.wdata);
               end
               if (seen == n_rows - 1) begin
                  settle <= 2;
               end
            end
            seen <= seen + 1;
         end
         // last store has left writeback but the self-jump has not
         if (settle == 1) begin
            if (retired !== exp_retired) begin
               retire_errors <= retire_errors + 1;
               $display("Mismatch retired count: expected %0d, actual %0d",
                        exp_retired, retired);
            end
            if (loads != count_load_rows()) begin
               errs++;
               $display("Mismatch load count: expected %0d, actual %0d",
                        count_load_rows(), loads);
            end
            finished <= 1'b1;
         end
         if (settle != 0) begin
            settle <= settle - 1;
         end
         store_errors <= store_errors + errs;
      end
   end

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
   parameter int half_period  = 10,
   parameter int reset_cycles = 4
) (
   output logic clk,
   output logic rstn
);

   initial begin
      clk = 1'b0;
      forever #(half_period) clk = ~clk;
   end

   // active high, dropped just after an edge
   initial begin
      rstn = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      #1 rstn = 1'b0;
   end

endmodule

/* bench/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

   localparam int n_rows     = 7;
   localparam int row_len    = 6;
   localparam int rom_words  = 64;
   localparam int mem_words  = 64;
   localparam int max_cycles = 1000;

   logic                clk;
   logic                rstn;
   logic [31:0]         rom_addr;
   logic [31:0]         rom_data;
   logic [31:0]         dmem_rdata;
   logic [31:0]         retired;
   pipe_pkg::dmem_req_t dmem;

   logic [31:0] rom      [rom_words];
   logic [31:0] data_mem [mem_words];

   // stimulus table with one short program per row
   logic [127:0] names    [n_rows];
   logic [31:0]  prog     [n_rows][row_len];
   logic [31:0]  exp_addr [n_rows];
   logic [31:0]  exp_val  [n_rows];
   logic         plus_mem [n_rows];
   logic [31:0]  src_addr [n_rows];
   logic [31:0]  exp_retired;
   int           n_added;

   int store_errors;
   int retire_errors;
   int seen;
   int timeouts;
   bit finished;

   function automatic logic [31:0] alu_rr(input logic [6:0] f7, input logic [2:0] f3,
                                          input int rd, input int rs1, input int rs2);
      return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
   endfunction

   function automatic logic [31:0] alu_imm(input int rd, input int rs1, input int imm);
      return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
   endfunction

   function automatic logic [31:0] load_word(input int rd, input int rs1, input int imm);
      return {12'(imm), 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
   endfunction

   function automatic logic [31:0] store_word(input int rs2, input int rs1, input int imm);
      logic [11:0] off;
      off = 12'(imm);
      return {off[11:5], 5'(rs2), 5'(rs1), 3'b010, off[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] branch_eq(input int rs1, input int rs2, input int imm);
      logic [12:0] off;
      off = 13'(imm);
      return {off[12], off[10:5], 5'(rs2), 5'(rs1), 3'b000, off[4:1], off[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] jump_link(input int rd, input int imm);
      logic [20:0] off;
      off = 21'(imm);
      return {off[20], off[10:1], off[11], off[19:12], 5'(rd), 7'b1101111};
   endfunction

   task automatic add_row(input logic [127:0] name, input logic [0:row_len-1][31:0] words,
                          input logic [31:0] addr, input logic [31:0] value,
                          input logic plus, input logic [31:0] src, input int count);
      names[n_added]    = name;
      exp_addr[n_added] = addr;
      exp_val[n_added]  = value;
      plus_mem[n_added] = plus;
      src_addr[n_added] = src;
      for (int i = 0; i < row_len; i++) begin
         prog[n_added][i] = words[i];
      end
      exp_retired = exp_retired + 32'(count);
      n_added++;
   endtask

   ////////////////////////////////////////
   // table, rom and data memory
   ////////////////////////////////////////

   initial begin : build
      void'($urandom(7));
      n_added     = 0;
      exp_retired = '0;
      // sub is funct7 0x20 while or and and use funct3 6 and 7
      add_row("alu_fwd",
              {alu_imm(1, 0, 21), alu_imm(2, 0, 13), alu_rr(7'h00, 3'h0, 3, 1, 2),
               alu_rr(7'h20, 3'h0, 4, 3, 1), alu_rr(7'h00, 3'h6, 5, 4, 3), store_word(5, 0, 64)},
              32'd64, 32'd47, 1'b0, '0, 6);
      add_row("and_sub",
              {alu_rr(7'h00, 3'h7, 6, 5, 3), alu_rr(7'h20, 3'h0, 7, 6, 1),
               store_word(7, 0, 68), 96'h0},
              32'd68, 32'd13, 1'b0, '0, 3);
      add_row("x0_write",
              {alu_imm(0, 1, 5), store_word(0, 0, 72), 128'h0},
              32'd72, 32'd0, 1'b0, '0, 2);
      // dependent addi right behind the load
      add_row("load_use",
              {load_word(8, 0, 128), alu_imm(9, 8, 25), store_word(9, 0, 76), 96'h0},
              32'd76, 32'd25, 1'b1, 32'd128, 3);
      // stores at 80 sit in the branch shadow
      add_row("beq_taken",
              {alu_imm(10, 0, 9), alu_imm(11, 0, 9), branch_eq(10, 11, 12),
               store_word(10, 0, 80), store_word(11, 0, 80), store_word(1, 0, 84)},
              32'd84, 32'd21, 1'b0, '0, 4);
      // jal sits at byte 120 so the link is 124
      add_row("jal_link",
              {jump_link(12, 12), store_word(0, 0, 88), store_word(0, 0, 88),
               store_word(12, 0, 88), 64'h0},
              32'd88, 32'd124, 1'b0, '0, 2);
      add_row("beq_not_taken",
              {alu_imm(13, 0, 3), branch_eq(13, 1, 8), store_word(13, 0, 92), 96'h0},
              32'd92, 32'd3, 1'b0, '0, 3);
      for (int a = 0; a < mem_words; a++) begin
         data_mem[a] = $urandom();
      end
      for (int a = 0; a < rom_words; a++) begin
         rom[a] = '0;
      end
      for (int r = 0; r < n_rows; r++) begin
         for (int i = 0; i < row_len; i++) begin
            rom[r * row_len + i] = prog[r][i];
         end
      end
      // park the core on a self-jump
      rom[n_rows * row_len] = jump_link(0, 0);
      forever begin
         @(posedge clk);
         if (dmem.we) begin
            data_mem[dmem.addr[7:2]] = dmem.wdata;
         end
      end
   end

   assign rom_data   = rom[rom_addr[7:2]];
   assign dmem_rdata = data_mem[dmem.addr[7:2]];

   tb_clock u_clock (.clk(clk), .rstn(rstn));

   core_top #(.reset_pc(32'h0)) DUT (
      .clk(clk), .rstn(rstn), .rom_addr(rom_addr), .rom_data(rom_data),
      .dmem(dmem), .dmem_rdata(dmem_rdata), .retired(retired)
   );

   tb_checker #(.n_rows(n_rows), .mem_words(mem_words)) u_checker (
      .clk(clk), .rstn(rstn), .dmem(dmem), .retired(retired), .names(names),
      .exp_addr(exp_addr), .exp_val(exp_val), .plus_mem(plus_mem), .src_addr(src_addr),
      .exp_retired(exp_retired), .data_mem(data_mem), .store_errors(store_errors),
      .retire_errors(retire_errors), .seen(seen), .finished(finished)
   );

   initial begin : run
      int cycles;
      timeouts = 0;
      cycles   = 0;
      while (!finished && cycles < max_cycles) begin
         @(negedge clk);
         cycles++;
      end
      if (!finished) begin
         timeouts = 1;
         $display("Timeout after %0d cycles with %0d of %0d table stores seen",
                  cycles, seen, n_rows);
      end
      $display("Errors: %0d memory, %0d retire, %0d timeout",
               store_errors, retire_errors, timeouts);
      if (store_errors + retire_errors + timeouts == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

/* design/core_top.sv */
`timescale 1ns/1ps

module core_top #(
   parameter logic [isa_pkg::xlen-1:0] reset_pc = '0
) (
   input  logic                     clk,
   input  logic                     rstn,
   output logic [isa_pkg::xlen-1:0] rom_addr,
   input  logic [isa_pkg::xlen-1:0] rom_data,
   output pipe_pkg::dmem_req_t      dmem,
   input  logic [isa_pkg::xlen-1:0] dmem_rdata,
   output logic [31:0]              retired
);

   pipe_pkg::fd_pkt_t             fd;
   isa_pkg::decoded_t             decoding;
   isa_pkg::reg_addr_t [1:0]      src;
   logic [1:0][isa_pkg::xlen-1:0] rs_val;
   logic [1:0][isa_pkg::xlen-1:0] op_val;
   logic [1:0]                    load_hit;
   pipe_pkg::res_pkt_t            exec_res;
   pipe_pkg::res_pkt_t            mem_res;
   logic                          stall;
   logic                          bubble;
   logic                          redirect;
   logic [isa_pkg::xlen-1:0]      redirect_pc;
   logic                          wb_en;
   isa_pkg::reg_addr_t            wb_rd;
   logic [isa_pkg::xlen-1:0]      wb_data;

   fetch_stage #(.reset_pc(reset_pc)) u_fetch (
      .clk(clk), .rstn(rstn), .stall(stall), .redirect(redirect),
      .redirect_pc(redirect_pc), .rom_addr(rom_addr), .rom_data(rom_data), .fd(fd)
   );

   decode_stage u_decode (
      .clk(clk), .rstn(rstn), .fd(fd), .wb_en(wb_en), .wb_rd(wb_rd),
      .wb_data(wb_data), .instr(decoding), .rs_val(rs_val)
   );

   ////////////////////////////////////////
   // one forwarder per source operand
   ////////////////////////////////////////

   assign src = {decoding.rs2, decoding.rs1};

   for (genvar i = 0; i < 2; i++) begin : g_fwd
      operand_forward u_fwd (
         .src(src[i]), .reg_val(rs_val[i]), .exec_res(exec_res), .mem_res(mem_res),
         .decoding(decoding), .value(op_val[i]), .load_hit(load_hit[i])
      );
   end

   hazard_ctrl u_hazard (
      .load_hit(load_hit), .redirect(redirect), .stall(stall), .bubble(bubble)
   );

   execute_stage u_execute (
      .clk(clk), .rstn(rstn), .bubble(bubble), .instr(decoding), .op_val(op_val),
      .exec_res(exec_res), .redirect(redirect), .redirect_pc(redirect_pc)
   );

   mem_wb_stage u_mem_wb (
      .clk(clk), .rstn(rstn), .exec_res(exec_res), .mem_res(mem_res), .dmem(dmem),
      .dmem_rdata(dmem_rdata), .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
      .retired(retired)
   );

endmodule

/* design/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
   input  logic                          clk,
   input  logic                          rstn,
   input  pipe_pkg::fd_pkt_t             fd,
   input  logic                          wb_en,
   input  isa_pkg::reg_addr_t            wb_rd,
   input  logic [isa_pkg::xlen-1:0]      wb_data,
   output isa_pkg::decoded_t             instr,
   output logic [1:0][isa_pkg::xlen-1:0] rs_val
);

   logic [6:0]                    funct7;
   logic [2:0]                    funct3;
   logic                          supported;
   logic [isa_pkg::xlen-1:0]      raw;
   isa_pkg::reg_addr_t [1:0]      rd_addr;
   logic [isa_pkg::xlen-1:0]      regs [1:31];

   assign raw    = fd.instr;
   assign funct7 = raw[31:25];
   assign funct3 = raw[14:12];

   ////////////////////////////////////////
   // decoder
   ////////////////////////////////////////

   // unused source fields stay x0 so the forwarders never match them
   always_comb begin
      instr     = '0;
      supported = 1'b0;
      instr.pc  = fd.pc;
      case (raw[6:0])
         isa_pkg::op_alu_r: begin
            instr.opcode     = isa_pkg::op_alu_r;
            instr.rd         = raw[11:7];
            instr.rs1        = raw[19:15];
            instr.rs2        = raw[24:20];
            instr.writes_reg = 1'b1;
            if (funct3 == isa_pkg::f3_add_sub && funct7 == isa_pkg::f7_base) begin
               supported    = 1'b1;
               instr.alu_op = isa_pkg::alu_add;
            end else if (funct3 == isa_pkg::f3_add_sub && funct7 == isa_pkg::f7_sub) begin
               supported    = 1'b1;
               instr.alu_op = isa_pkg::alu_sub;
            end else if (funct3 == isa_pkg::f3_and && funct7 == isa_pkg::f7_base) begin
               supported    = 1'b1;
               instr.alu_op = isa_pkg::alu_and;
            end else if (funct3 == isa_pkg::f3_or && funct7 == isa_pkg::f7_base) begin
               supported    = 1'b1;
               instr.alu_op = isa_pkg::alu_or;
            end
         end
         isa_pkg::op_alu_i, isa_pkg::op_load: begin
            instr.opcode     = isa_pkg::opcode_e'(raw[6:0]);
            instr.rd         = raw[11:7];
            instr.rs1        = raw[19:15];
            instr.imm        = {{20{raw[31]}}, raw[31:20]};
            instr.writes_reg = 1'b1;
            // addi or lw only
            supported        = (raw[6:0] == isa_pkg::op_alu_i) ?
                               (funct3 == isa_pkg::f3_add_sub) : (funct3 == isa_pkg::f3_word);
         end
         isa_pkg::op_store: begin
            instr.opcode = isa_pkg::op_store;
            instr.rs1    = raw[19:15];
            instr.rs2    = raw[24:20];
            instr.imm    = {{20{raw[31]}}, raw[31:25], raw[11:7]};
            supported    = (funct3 == isa_pkg::f3_word);
         end
         isa_pkg::op_branch: begin
            instr.opcode = isa_pkg::op_branch;
            instr.rs1    = raw[19:15];
            instr.rs2    = raw[24:20];
            instr.imm    = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
            supported    = (funct3 == isa_pkg::f3_beq);
         end
         isa_pkg::op_jal: begin
            instr.opcode     = isa_pkg::op_jal;
            instr.rd         = raw[11:7];
            instr.imm        = {{11{raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};
            instr.writes_reg = 1'b1;
            supported        = 1'b1;
         end
         default: ;
      endcase
      // x0 destination never writes back
      if (instr.rd == '0) begin
         instr.writes_reg = 1'b0;
      end
      instr.valid = fd.valid && supported;
      if (!instr.valid) begin
         instr = '0;
      end
   end

   ////////////////////////////////////////
   // register file
   ////////////////////////////////////////

   assign rd_addr = {instr.rs2, instr.rs1};

   always_ff @(posedge clk) begin
      if (wb_en && wb_rd != '0) begin
         regs[wb_rd] <= wb_data;
      end
   end

   // write-through so writeback is visible the same cycle
   always_comb begin
      for (int i = 0; i < 2; i++) begin
         if (rd_addr[i] == '0) begin
            rs_val[i] = '0;
         end else if (wb_en && wb_rd == rd_addr[i]) begin
            rs_val[i] = wb_data;
         end else begin
            rs_val[i] = regs[rd_addr[i]];
         end
      end
   end

   // writeback never targets x0
   assert property (@(posedge clk) disable iff (rstn) !(wb_en && wb_rd == '0));

endmodule

/* design/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic                          bubble,
   input  isa_pkg::decoded_t             instr,
   input  logic [1:0][isa_pkg::xlen-1:0] op_val,
   output pipe_pkg::res_pkt_t            exec_res,
   output logic                          redirect,
   output logic [isa_pkg::xlen-1:0]      redirect_pc
);

   isa_pkg::decoded_t             de;
   logic [1:0][isa_pkg::xlen-1:0] opv;
   logic [isa_pkg::xlen-1:0]      b;
   logic [isa_pkg::xlen-1:0]      alu_out;

   always_ff @(posedge clk) begin
      if (rstn || bubble) begin
         de.valid <= 1'b0;
      end else begin
         de  <= instr;
         opv <= op_val;
      end
   end

   // second operand is rs2 for r-type, immediate otherwise
   assign b = (de.opcode == isa_pkg::op_alu_r) ? opv[1] : de.imm;

   always_comb begin
      case (de.alu_op)
         isa_pkg::alu_sub: alu_out = opv[0] - b;
         isa_pkg::alu_and: alu_out = opv[0] & b;
         isa_pkg::alu_or:  alu_out = opv[0] | b;
         default:          alu_out = opv[0] + b;
      endcase
   end

   ////////////////////////////////////////
   // branch and jump
   ////////////////////////////////////////

   assign redirect    = de.valid &&
                        ((de.opcode == isa_pkg::op_branch && opv[0] == opv[1]) ||
                         de.opcode == isa_pkg::op_jal);
   assign redirect_pc = de.pc + de.imm;

   always_comb begin
      exec_res.instr      = de;
      exec_res.store_data = opv[1];
      // link value for jal
      exec_res.result     = (de.opcode == isa_pkg::op_jal) ? de.pc + 32'd4 : alu_out;
   end

endmodule

/* design/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage #(
   parameter logic [isa_pkg::xlen-1:0] reset_pc = '0
) (
   input  logic                     clk,
   input  logic                     rstn,
   input  logic                     stall,
   input  logic                     redirect,
   input  logic [isa_pkg::xlen-1:0] redirect_pc,
   output logic [isa_pkg::xlen-1:0] rom_addr,
   input  logic [isa_pkg::xlen-1:0] rom_data,
   output pipe_pkg::fd_pkt_t        fd
);

   logic [isa_pkg::xlen-1:0] pc;

   assign rom_addr = pc;

   always_ff @(posedge clk) begin
      if (rstn) begin
         pc       <= reset_pc;
         fd.valid <= 1'b0;
      end else if (redirect) begin
         // younger fetch is dropped
         pc       <= redirect_pc;
         fd.valid <= 1'b0;
      end else if (!stall) begin
         pc       <= pc + 32'd4;
         fd.valid <= 1'b1;
         fd.pc    <= pc;
         fd.instr <= rom_data;
      end
   end

   // jump targets from execute stay on word boundaries
   assert property (@(posedge clk) disable iff (rstn) rom_addr[1:0] == 2'b00);

endmodule

/* design/hazard_ctrl.sv */
`timescale 1ns/1ps

module hazard_ctrl (
   input  logic [1:0] load_hit,
   input  logic       redirect,
   output logic       stall,
   output logic       bubble
);

   // redirect discards the dependent instruction anyway
   assign stall  = (|load_hit) && !redirect;
   assign bubble = stall || redirect;

   // a redirecting instruction in execute is never a load
   always_comb begin
      assert final (!((|load_hit) && redirect));
   end

endmodule

/* design/isa_pkg.sv */
package isa_pkg;

   localparam int xlen = 32;

   typedef logic [4:0] reg_addr_t;

   // major opcodes, RISC-V encoding values
   typedef enum logic [6:0] {
      op_none   = 7'b0000000,
      op_load   = 7'b0000011,
      op_alu_i  = 7'b0010011,
      op_store  = 7'b0100011,
      op_alu_r  = 7'b0110011,
      op_branch = 7'b1100011,
      op_jal    = 7'b1101111
   } opcode_e;

   typedef enum logic [1:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or
   } alu_op_e;

   // funct fields of the supported subset
   localparam logic [2:0] f3_add_sub = 3'b000;
   localparam logic [2:0] f3_word    = 3'b010;
   localparam logic [2:0] f3_or      = 3'b110;
   localparam logic [2:0] f3_and     = 3'b111;
   localparam logic [2:0] f3_beq     = 3'b000;
   localparam logic [6:0] f7_base    = 7'b0000000;
   localparam logic [6:0] f7_sub     = 7'b0100000;

   typedef struct packed {
      logic            valid;
      opcode_e         opcode;
      alu_op_e         alu_op;
      reg_addr_t       rd;
      reg_addr_t       rs1;
      reg_addr_t       rs2;
      logic [xlen-1:0] imm;
      logic            writes_reg;
      logic [xlen-1:0] pc;
   } decoded_t;

endpackage

/* design/mem_wb_stage.sv */
`timescale 1ns/1ps

module mem_wb_stage (
   input  logic                     clk,
   input  logic                     rstn,
   input  pipe_pkg::res_pkt_t       exec_res,
   output pipe_pkg::res_pkt_t       mem_res,
   output pipe_pkg::dmem_req_t      dmem,
   input  logic [isa_pkg::xlen-1:0] dmem_rdata,
   output logic                     wb_en,
   output isa_pkg::reg_addr_t       wb_rd,
   output logic [isa_pkg::xlen-1:0] wb_data,
   output logic [31:0]              retired
);

   pipe_pkg::res_pkt_t mem_q;
   pipe_pkg::res_pkt_t wb_q;

   always_ff @(posedge clk) begin
      if (rstn) begin
         mem_q.instr.valid <= 1'b0;
         wb_q.instr.valid  <= 1'b0;
      end else begin
         mem_q <= exec_res;
         wb_q  <= mem_res;
      end
   end

   ////////////////////////////////////////
   // memory access
   ////////////////////////////////////////

   assign dmem.addr  = mem_q.result;
   assign dmem.wdata = mem_q.store_data;
   assign dmem.we    = mem_q.instr.valid && mem_q.instr.opcode == isa_pkg::op_store;
   assign dmem.re    = mem_q.instr.valid && mem_q.instr.opcode == isa_pkg::op_load;

   always_comb begin
      mem_res = mem_q;
      if (mem_q.instr.opcode == isa_pkg::op_load) begin
         mem_res.result = dmem_rdata;
      end
   end

   // writeback
   assign wb_en   = wb_q.instr.valid && wb_q.instr.writes_reg;
   assign wb_rd   = wb_q.instr.rd;
   assign wb_data = wb_q.result;

   always_ff @(posedge clk) begin
      if (rstn) begin
         retired <= '0;
      end else if (wb_q.instr.valid) begin
         retired <= retired + 32'd1;
      end
   end

endmodule

/* design/operand_forward.sv */
`timescale 1ns/1ps

module operand_forward (
   input  isa_pkg::reg_addr_t       src,
   input  logic [isa_pkg::xlen-1:0] reg_val,
   input  pipe_pkg::res_pkt_t       exec_res,
   input  pipe_pkg::res_pkt_t       mem_res,
   input  isa_pkg::decoded_t        decoding,
   output logic [isa_pkg::xlen-1:0] value,
   output logic                     load_hit
);

   logic               exec_match;
   logic               mem_match;
   pipe_pkg::fwd_sel_e sel;

   assign exec_match = exec_res.instr.valid && exec_res.instr.writes_reg &&
                       exec_res.instr.rd != '0 && exec_res.instr.rd == src;
   assign mem_match  = mem_res.instr.valid && mem_res.instr.writes_reg &&
                       mem_res.instr.rd != '0 && mem_res.instr.rd == src;

   // youngest producer wins
   always_comb begin
      if (exec_match) begin
         sel = pipe_pkg::fwd_exec;
      end else if (mem_match) begin
         sel = pipe_pkg::fwd_mem;
      end else begin
         sel = pipe_pkg::fwd_regfile;
      end
      case (sel)
         pipe_pkg::fwd_exec: value = exec_res.result;
         pipe_pkg::fwd_mem:  value = mem_res.result;
         default:            value = reg_val;
      endcase
   end

   // load data not there yet, needs one stall
   assign load_hit = decoding.valid && exec_match &&
                     exec_res.instr.opcode == isa_pkg::op_load;

endmodule

/* design/pipe_pkg.sv */
package pipe_pkg;

   typedef enum logic [1:0] {
      fwd_regfile,
      fwd_exec,
      fwd_mem
   } fwd_sel_e;

   typedef struct packed {
      logic                     valid;
      logic [isa_pkg::xlen-1:0] pc;
      logic [isa_pkg::xlen-1:0] instr;
   } fd_pkt_t;

   // result word is the load data once past the memory stage
   typedef struct packed {
      isa_pkg::decoded_t        instr;
      logic [isa_pkg::xlen-1:0] result;
      logic [isa_pkg::xlen-1:0] store_data;
   } res_pkt_t;

   typedef struct packed {
      logic [isa_pkg::xlen-1:0] addr;
      logic [isa_pkg::xlen-1:0] wdata;
      logic                     we;
      logic                     re;
   } dmem_req_t;

endpackage

/* files.f */
design/isa_pkg.sv
design/pipe_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/operand_forward.sv
design/hazard_ctrl.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/core_top.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_top.sv
